// File: common/issue_pkg.sv
`default_nettype none

package issue_pkg;

  localparam int queue_depth = 8;
  // stall rises once more than half of the slots are taken
  localparam int stall_level = queue_depth / 2;
  localparam int queue_index_width = 3;
  localparam int count_width = queue_index_width + 1;

  localparam int data_width = 32;
  localparam int reg_addr_width = 5;
  localparam int reg_count = 2 ** reg_addr_width;
  localparam int class_width = 2;
  localparam int alu_op_width = 3;

  // pc, class, alu op, rd, wren, rs1, rs1_en, rs2, rs2_en, imm, use_imm
  localparam int record_width =
    2 * data_width + class_width + alu_op_width + 3 * reg_addr_width + 4;

  typedef enum logic [6:0] {
    opcode_op = 7'b0110011,
    opcode_op_imm = 7'b0010011,
    opcode_fence = 7'b0001111
  } opcode_type;

  typedef enum logic [alu_op_width-1:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl
  } alu_op_type;

  typedef enum logic [class_width-1:0] {
    class_alu,
    class_shift,
    class_fence,
    class_illegal
  } instr_class_type;

endpackage

`default_nettype wire

// File: source/instr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decode (
  input logic clock,
  input logic reset,
  input logic stall,
  input logic fetch_valid0,
  input logic fetch_valid1,
  input logic [issue_pkg::data_width-1:0] fetch_instr0,
  input logic [issue_pkg::data_width-1:0] fetch_instr1,
  input logic [issue_pkg::data_width-1:0] fetch_pc0,
  input logic [issue_pkg::data_width-1:0] fetch_pc1,
  output logic dec_valid0,
  output logic [issue_pkg::data_width-1:0] dec_pc0,
  output issue_pkg::instr_class_type dec_class0,
  output issue_pkg::alu_op_type dec_alu_op0,
  output logic [issue_pkg::reg_addr_width-1:0] dec_rd0,
  output logic dec_wren0,
  output logic [issue_pkg::reg_addr_width-1:0] dec_rs1_0,
  output logic dec_rs1_en0,
  output logic [issue_pkg::reg_addr_width-1:0] dec_rs2_0,
  output logic dec_rs2_en0,
  output logic [issue_pkg::data_width-1:0] dec_imm0,
  output logic dec_use_imm0,
  output logic dec_valid1,
  output logic [issue_pkg::data_width-1:0] dec_pc1,
  output issue_pkg::instr_class_type dec_class1,
  output issue_pkg::alu_op_type dec_alu_op1,
  output logic [issue_pkg::reg_addr_width-1:0] dec_rd1,
  output logic dec_wren1,
  output logic [issue_pkg::reg_addr_width-1:0] dec_rs1_1,
  output logic dec_rs1_en1,
  output logic [issue_pkg::reg_addr_width-1:0] dec_rs2_1,
  output logic dec_rs2_en1,
  output logic [issue_pkg::data_width-1:0] dec_imm1,
  output logic dec_use_imm1
);

  logic [issue_pkg::data_width-1:0] instr [2];
  logic [issue_pkg::data_width-1:0] pc [2];
  issue_pkg::instr_class_type cls [2];
  issue_pkg::alu_op_type op [2];
  logic [issue_pkg::data_width-1:0] imm [2];
  logic [1:0] wren;
  logic [1:0] rs1_en;
  logic [1:0] rs2_en;
  logic [1:0] use_imm;
  logic [1:0] valid;
  logic reg_form;
  logic f7_zero;
  logic f7_alt;
  logic sel;

  assign instr[0] = fetch_instr0;
  assign instr[1] = fetch_instr1;
  assign pc[0] = fetch_pc0;
  assign pc[1] = fetch_pc1;

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      cls[i] = issue_pkg::class_illegal;
      op[i] = issue_pkg::alu_add;
      wren[i] = 1'b0;
      rs1_en[i] = 1'b0;
      rs2_en[i] = 1'b0;
      use_imm[i] = 1'b0;
      imm[i] = {{(issue_pkg::data_width-12){instr[i][31]}}, instr[i][31:20]};
      reg_form = instr[i][5];
      f7_zero = instr[i][31:25] == 7'b0000000;
      f7_alt = instr[i][31:25] == 7'b0100000;
      case (issue_pkg::opcode_type'(instr[i][6:0]))
        issue_pkg::opcode_op, issue_pkg::opcode_op_imm: begin
          wren[i] = 1'b1;
          rs1_en[i] = 1'b1;
          rs2_en[i] = reg_form;
          use_imm[i] = !reg_form;
          // the immediate forms carry no funct7 except for the shifts
          cls[i] = (f7_zero || !reg_form) ? issue_pkg::class_alu : issue_pkg::class_illegal;
          case (instr[i][14:12])
            3'b000: begin
              if (reg_form && f7_alt) begin
                op[i] = issue_pkg::alu_sub;
                cls[i] = issue_pkg::class_alu;
              end
            end
            3'b111: op[i] = issue_pkg::alu_and;
            3'b110: op[i] = issue_pkg::alu_or;
            3'b100: op[i] = issue_pkg::alu_xor;
            3'b001: begin
              op[i] = issue_pkg::alu_sll;
              cls[i] = f7_zero ? issue_pkg::class_shift : issue_pkg::class_illegal;
            end
            3'b101: begin
              op[i] = issue_pkg::alu_srl;
              cls[i] = f7_zero ? issue_pkg::class_shift : issue_pkg::class_illegal;
            end
            default: cls[i] = issue_pkg::class_illegal;
          endcase
        end
        issue_pkg::opcode_fence: begin
          if (instr[i][14:12] == 3'b000) begin
            cls[i] = issue_pkg::class_fence;
          end
        end
        default: cls[i] = issue_pkg::class_illegal;
      endcase
    end
  end

  assign valid[0] = fetch_valid0 && cls[0] != issue_pkg::class_illegal;
  assign valid[1] = fetch_valid1 && cls[1] != issue_pkg::class_illegal;
  // a dropped lane 0 lets lane 1 move down so the older slot stays filled
  assign sel = !valid[0];

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      dec_valid0 <= 1'b0;
      dec_valid1 <= 1'b0;
    end else if (stall) begin
      dec_valid0 <= 1'b0;
      dec_valid1 <= 1'b0;
    end else begin
      dec_valid0 <= valid[0] || valid[1];
      dec_valid1 <= valid[0] && valid[1];
    end
  end

  always_ff @(posedge clock) begin
    if (!stall) begin
      dec_pc0 <= pc[sel];
      dec_class0 <= cls[sel];
      dec_alu_op0 <= op[sel];
      dec_rd0 <= instr[sel][11:7];
      dec_wren0 <= wren[sel];
      dec_rs1_0 <= instr[sel][19:15];
      dec_rs1_en0 <= rs1_en[sel];
      dec_rs2_0 <= instr[sel][24:20];
      dec_rs2_en0 <= rs2_en[sel];
      dec_imm0 <= imm[sel];
      dec_use_imm0 <= use_imm[sel];
      dec_pc1 <= pc[1];
      dec_class1 <= cls[1];
      dec_alu_op1 <= op[1];
      dec_rd1 <= instr[1][11:7];
      dec_wren1 <= wren[1];
      dec_rs1_1 <= instr[1][19:15];
      dec_rs1_en1 <= rs1_en[1];
      dec_rs2_1 <= instr[1][24:20];
      dec_rs2_en1 <= rs2_en[1];
      dec_imm1 <= imm[1];
      dec_use_imm1 <= use_imm[1];
    end
  end

  lane_order: assert property (@(posedge clock) disable iff (!reset)
    dec_valid1 |-> dec_valid0);

endmodule

`default_nettype wire

// File: hazard/issue_queue.sv
`timescale 1ns/1ps
`default_nettype none

module issue_queue (
  input logic clock,
  input logic reset,
  input logic clear,
  input logic dec_valid0,
  input logic [issue_pkg::data_width-1:0] dec_pc0,
  input issue_pkg::instr_class_type dec_class0,
  input issue_pkg::alu_op_type dec_alu_op0,
  input logic [issue_pkg::reg_addr_width-1:0] dec_rd0,
  input logic dec_wren0,
  input logic [issue_pkg::reg_addr_width-1:0] dec_rs1_0,
  input logic dec_rs1_en0,
  input logic [issue_pkg::reg_addr_width-1:0] dec_rs2_0,
  input logic dec_rs2_en0,
  input logic [issue_pkg::data_width-1:0] dec_imm0,
  input logic dec_use_imm0,
  input logic dec_valid1,
  input logic [issue_pkg::data_width-1:0] dec_pc1,
  input issue_pkg::instr_class_type dec_class1,
  input issue_pkg::alu_op_type dec_alu_op1,
  input logic [issue_pkg::reg_addr_width-1:0] dec_rd1,
  input logic dec_wren1,
  input logic [issue_pkg::reg_addr_width-1:0] dec_rs1_1,
  input logic dec_rs1_en1,
  input logic [issue_pkg::reg_addr_width-1:0] dec_rs2_1,
  input logic dec_rs2_en1,
  input logic [issue_pkg::data_width-1:0] dec_imm1,
  input logic dec_use_imm1,
  output logic iss_valid0,
  output logic [issue_pkg::data_width-1:0] iss_pc0,
  output issue_pkg::instr_class_type iss_class0,
  output issue_pkg::alu_op_type iss_alu_op0,
  output logic [issue_pkg::reg_addr_width-1:0] iss_rd0,
  output logic iss_wren0,
  output logic [issue_pkg::reg_addr_width-1:0] iss_rs1_0,
  output logic iss_rs1_en0,
  output logic [issue_pkg::reg_addr_width-1:0] iss_rs2_0,
  output logic iss_rs2_en0,
  output logic [issue_pkg::data_width-1:0] iss_imm0,
  output logic iss_use_imm0,
  output logic iss_valid1,
  output logic [issue_pkg::data_width-1:0] iss_pc1,
  output issue_pkg::instr_class_type iss_class1,
  output issue_pkg::alu_op_type iss_alu_op1,
  output logic [issue_pkg::reg_addr_width-1:0] iss_rd1,
  output logic iss_wren1,
  output logic [issue_pkg::reg_addr_width-1:0] iss_rs1_1,
  output logic iss_rs1_en1,
  output logic [issue_pkg::reg_addr_width-1:0] iss_rs2_1,
  output logic iss_rs2_en1,
  output logic [issue_pkg::data_width-1:0] iss_imm1,
  output logic iss_use_imm1,
  output logic stall
);

  logic [issue_pkg::record_width-1:0] mem [issue_pkg::queue_depth];
  logic [issue_pkg::record_width-1:0] rec_in0;
  logic [issue_pkg::record_width-1:0] rec_in1;
  logic [issue_pkg::record_width-1:0] head [2];
  logic [issue_pkg::queue_index_width-1:0] rptr;
  logic [issue_pkg::queue_index_width-1:0] rptr1;
  logic [issue_pkg::queue_index_width-1:0] wptr;
  logic [issue_pkg::queue_index_width-1:0] wptr1;
  logic [issue_pkg::count_width-1:0] count;
  logic [issue_pkg::count_width-1:0] avail;
  logic [issue_pkg::count_width-1:0] count_next;
  logic [1:0] arrivals;
  logic [1:0] pass;
  logic [issue_pkg::class_width-1:0] class_bits0;
  logic [issue_pkg::class_width-1:0] class_bits1;
  logic [issue_pkg::alu_op_width-1:0] op_bits0;
  logic [issue_pkg::alu_op_width-1:0] op_bits1;
  logic raw;
  logic single;

  assign rec_in0 = {dec_pc0, dec_class0, dec_alu_op0, dec_rd0, dec_wren0, dec_rs1_0,
                    dec_rs1_en0, dec_rs2_0, dec_rs2_en0, dec_imm0, dec_use_imm0};
  assign rec_in1 = {dec_pc1, dec_class1, dec_alu_op1, dec_rd1, dec_wren1, dec_rs1_1,
                    dec_rs1_en1, dec_rs2_1, dec_rs2_en1, dec_imm1, dec_use_imm1};

  // pointers wrap naturally since the depth is a power of two
  assign rptr1 = rptr + 1'b1;
  assign wptr1 = wptr + 1'b1;
  assign arrivals = {1'b0, dec_valid0} + {1'b0, dec_valid1};
  assign avail = count + issue_pkg::count_width'(arrivals);

  // arrivals sit right behind the stored records, so they can fall through
  always_comb begin
    head[0] = (count != '0) ? mem[rptr] : rec_in0;
    if (count > 1) begin
      head[1] = mem[rptr1];
    end else if (count == 1) begin
      head[1] = rec_in0;
    end else begin
      head[1] = rec_in1;
    end
  end

  assign {iss_pc0, class_bits0, op_bits0, iss_rd0, iss_wren0, iss_rs1_0, iss_rs1_en0,
          iss_rs2_0, iss_rs2_en0, iss_imm0, iss_use_imm0} = head[0];
  assign {iss_pc1, class_bits1, op_bits1, iss_rd1, iss_wren1, iss_rs1_1, iss_rs1_en1,
          iss_rs2_1, iss_rs2_en1, iss_imm1, iss_use_imm1} = head[1];
  assign iss_class0 = issue_pkg::instr_class_type'(class_bits0);
  assign iss_class1 = issue_pkg::instr_class_type'(class_bits1);
  assign iss_alu_op0 = issue_pkg::alu_op_type'(op_bits0);
  assign iss_alu_op1 = issue_pkg::alu_op_type'(op_bits1);

  always_comb begin
    raw = iss_wren0 && iss_rd0 != '0 &&
          ((iss_rs1_en1 && iss_rs1_1 == iss_rd0) || (iss_rs2_en1 && iss_rs2_1 == iss_rd0));
    // one shifter, and a fence never rides as the younger of a pair
    single = iss_class1 == issue_pkg::class_fence || raw ||
             (iss_class0 == issue_pkg::class_shift && iss_class1 == issue_pkg::class_shift);
    if (clear || avail == '0) begin
      pass = 2'd0;
    end else if (avail == 1 || single) begin
      pass = 2'd1;
    end else begin
      pass = 2'd2;
    end
    count_next = clear ? '0 : avail - issue_pkg::count_width'(pass);
  end

  assign iss_valid0 = pass != 2'd0;
  assign iss_valid1 = pass == 2'd2;

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      rptr <= '0;
      wptr <= '0;
      count <= '0;
      stall <= 1'b0;
    end else begin
      count <= count_next;
      stall <= count_next > issue_pkg::stall_level;
      if (clear) begin
        rptr <= wptr;
      end else begin
        rptr <= rptr + issue_pkg::queue_index_width'(pass);
        wptr <= wptr + issue_pkg::queue_index_width'(arrivals);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (dec_valid0) begin
      mem[wptr] <= rec_in0;
    end
    if (dec_valid1) begin
      mem[wptr1] <= rec_in1;
    end
  end

  count_bound: assert property (@(posedge clock) disable iff (!reset)
    count <= issue_pkg::queue_depth);

  empty_no_stall: assert property (@(posedge clock) disable iff (!reset)
    count == '0 |-> !stall);

  pair_no_raw: assert property (@(posedge clock) disable iff (!reset)
    iss_valid1 && iss_wren0 && iss_rd0 != '0 |->
      !(iss_rs1_en1 && iss_rs1_1 == iss_rd0) && !(iss_rs2_en1 && iss_rs2_1 == iss_rd0));

endmodule

`default_nettype wire

// File: source/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
  input logic clock,
  input logic reset,
  input logic iss_valid0,
  input logic [issue_pkg::data_width-1:0] iss_pc0,
  input issue_pkg::instr_class_type iss_class0,
  input issue_pkg::alu_op_type iss_alu_op0,
  input logic [issue_pkg::reg_addr_width-1:0] iss_rd0,
  input logic iss_wren0,
  input logic [issue_pkg::reg_addr_width-1:0] iss_rs1_0,
  input logic iss_rs1_en0,
  input logic [issue_pkg::reg_addr_width-1:0] iss_rs2_0,
  input logic iss_rs2_en0,
  input logic [issue_pkg::data_width-1:0] iss_imm0,
  input logic iss_use_imm0,
  input logic iss_valid1,
  input logic [issue_pkg::data_width-1:0] iss_pc1,
  input issue_pkg::instr_class_type iss_class1,
  input issue_pkg::alu_op_type iss_alu_op1,
  input logic [issue_pkg::reg_addr_width-1:0] iss_rd1,
  input logic iss_wren1,
  input logic [issue_pkg::reg_addr_width-1:0] iss_rs1_1,
  input logic iss_rs1_en1,
  input logic [issue_pkg::reg_addr_width-1:0] iss_rs2_1,
  input logic iss_rs2_en1,
  input logic [issue_pkg::data_width-1:0] iss_imm1,
  input logic iss_use_imm1,
  output logic retire_valid0,
  output logic retire_valid1,
  output logic [issue_pkg::data_width-1:0] retire_pc0,
  output logic [issue_pkg::data_width-1:0] retire_pc1,
  output logic wb_valid0,
  output logic wb_valid1,
  output logic [issue_pkg::reg_addr_width-1:0] wb_addr0,
  output logic [issue_pkg::reg_addr_width-1:0] wb_addr1,
  output logic [issue_pkg::data_width-1:0] wb_data0,
  output logic [issue_pkg::data_width-1:0] wb_data1
);

  logic [issue_pkg::data_width-1:0] regs [issue_pkg::reg_count];
  logic [issue_pkg::data_width-1:0] src_a0;
  logic [issue_pkg::data_width-1:0] src_b0;
  logic [issue_pkg::data_width-1:0] src_a1;
  logic [issue_pkg::data_width-1:0] src_b1;
  logic [issue_pkg::data_width-1:0] shift_a;
  logic [4:0] shamt;
  logic [issue_pkg::data_width-1:0] shift_result;
  logic [issue_pkg::data_width-1:0] result0;
  logic [issue_pkg::data_width-1:0] result1;
  logic shift_lane1;
  logic shift_left;
  logic write0;
  logic write1;

  function automatic logic [issue_pkg::data_width-1:0] logic_op(
    input issue_pkg::alu_op_type op,
    input logic [issue_pkg::data_width-1:0] a,
    input logic [issue_pkg::data_width-1:0] b
  );
    case (op)
      issue_pkg::alu_sub: return a - b;
      issue_pkg::alu_and: return a & b;
      issue_pkg::alu_or: return a | b;
      issue_pkg::alu_xor: return a ^ b;
      default: return a + b;
    endcase
  endfunction

  // x0 is cleared at reset and never written, so it always reads zero
  assign src_a0 = iss_rs1_en0 ? regs[iss_rs1_0] : '0;
  assign src_a1 = iss_rs1_en1 ? regs[iss_rs1_1] : '0;
  assign src_b0 = iss_use_imm0 ? iss_imm0 : (iss_rs2_en0 ? regs[iss_rs2_0] : '0);
  assign src_b1 = iss_use_imm1 ? iss_imm1 : (iss_rs2_en1 ? regs[iss_rs2_1] : '0);

  // the single shifter goes to whichever lane holds the shift
  assign shift_lane1 = iss_valid1 && iss_class1 == issue_pkg::class_shift;
  assign shift_a = shift_lane1 ? src_a1 : src_a0;
  assign shamt = shift_lane1 ? src_b1[4:0] : src_b0[4:0];
  assign shift_left = (shift_lane1 ? iss_alu_op1 : iss_alu_op0) == issue_pkg::alu_sll;
  assign shift_result = shift_left ? shift_a << shamt : shift_a >> shamt;

  assign result0 = iss_class0 == issue_pkg::class_shift ? shift_result :
                   logic_op(iss_alu_op0, src_a0, src_b0);
  assign result1 = iss_class1 == issue_pkg::class_shift ? shift_result :
                   logic_op(iss_alu_op1, src_a1, src_b1);

  assign write0 = iss_valid0 && iss_wren0 && iss_rd0 != '0;
  assign write1 = iss_valid1 && iss_wren1 && iss_rd1 != '0;

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      retire_valid0 <= 1'b0;
      retire_valid1 <= 1'b0;
      wb_valid0 <= 1'b0;
      wb_valid1 <= 1'b0;
      regs <= '{default: '0};
    end else begin
      retire_valid0 <= iss_valid0;
      retire_valid1 <= iss_valid1;
      wb_valid0 <= write0;
      wb_valid1 <= write1;
      if (write0) begin
        regs[iss_rd0] <= result0;
      end
      // lane 1 is younger and wins when both lanes name the same rd
      if (write1) begin
        regs[iss_rd1] <= result1;
      end
    end
  end

  always_ff @(posedge clock) begin
    retire_pc0 <= iss_pc0;
    retire_pc1 <= iss_pc1;
    wb_addr0 <= iss_rd0;
    wb_addr1 <= iss_rd1;
    wb_data0 <= result0;
    wb_data1 <= result1;
  end

  one_shifter: assert property (@(posedge clock) disable iff (!reset)
    !(iss_valid0 && iss_valid1 && iss_class0 == issue_pkg::class_shift &&
      iss_class1 == issue_pkg::class_shift));

  wb0_retired: assert property (@(posedge clock) disable iff (!reset)
    wb_valid0 |-> retire_valid0);

  wb1_retired: assert property (@(posedge clock) disable iff (!reset)
    wb_valid1 |-> retire_valid1);

endmodule

`default_nettype wire

// File: source/issue_top.sv
`timescale 1ns/1ps
`default_nettype none

module issue_top (
  input logic clock,
  input logic reset,
  input logic clear,
  input logic fetch_valid0,
  input logic fetch_valid1,
  input logic [issue_pkg::data_width-1:0] fetch_instr0,
  input logic [issue_pkg::data_width-1:0] fetch_instr1,
  input logic [issue_pkg::data_width-1:0] fetch_pc0,
  input logic [issue_pkg::data_width-1:0] fetch_pc1,
  output logic fetch_stall,
  output logic retire_valid0,
  output logic retire_valid1,
  output logic [issue_pkg::data_width-1:0] retire_pc0,
  output logic [issue_pkg::data_width-1:0] retire_pc1,
  output logic wb_valid0,
  output logic wb_valid1,
  output logic [issue_pkg::reg_addr_width-1:0] wb_addr0,
  output logic [issue_pkg::reg_addr_width-1:0] wb_addr1,
  output logic [issue_pkg::data_width-1:0] wb_data0,
  output logic [issue_pkg::data_width-1:0] wb_data1
);

  logic dec_valid0, dec_valid1;
  logic [issue_pkg::data_width-1:0] dec_pc0, dec_pc1;
  issue_pkg::instr_class_type dec_class0, dec_class1;
  issue_pkg::alu_op_type dec_alu_op0, dec_alu_op1;
  logic [issue_pkg::reg_addr_width-1:0] dec_rd0, dec_rd1;
  logic dec_wren0, dec_wren1;
  logic [issue_pkg::reg_addr_width-1:0] dec_rs1_0, dec_rs1_1;
  logic dec_rs1_en0, dec_rs1_en1;
  logic [issue_pkg::reg_addr_width-1:0] dec_rs2_0, dec_rs2_1;
  logic dec_rs2_en0, dec_rs2_en1;
  logic [issue_pkg::data_width-1:0] dec_imm0, dec_imm1;
  logic dec_use_imm0, dec_use_imm1;

  logic iss_valid0, iss_valid1;
  logic [issue_pkg::data_width-1:0] iss_pc0, iss_pc1;
  issue_pkg::instr_class_type iss_class0, iss_class1;
  issue_pkg::alu_op_type iss_alu_op0, iss_alu_op1;
  logic [issue_pkg::reg_addr_width-1:0] iss_rd0, iss_rd1;
  logic iss_wren0, iss_wren1;
  logic [issue_pkg::reg_addr_width-1:0] iss_rs1_0, iss_rs1_1;
  logic iss_rs1_en0, iss_rs1_en1;
  logic [issue_pkg::reg_addr_width-1:0] iss_rs2_0, iss_rs2_1;
  logic iss_rs2_en0, iss_rs2_en1;
  logic [issue_pkg::data_width-1:0] iss_imm0, iss_imm1;
  logic iss_use_imm0, iss_use_imm1;

  // port names match the wires above, only the stall level is renamed
  instr_decode u_decode (
    .stall(fetch_stall),
    .*
  );

  issue_queue u_queue (
    .stall(fetch_stall),
    .*
  );

  exec_unit u_exec (
    .*
  );

endmodule

`default_nettype wire

// File: tests/issue_tb.sv
`timescale 1ns/1ps
`default_nettype none

module issue_tb;

  // kind codes 0 to 6 are add sub and or xor sll srl
  // 7 to 12 are addi andi ori xori slli srli, and 13 is fence
  typedef struct packed {
    logic [31:0] pc;
    logic [3:0] kind;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [31:0] imm;
  } instr_info;

  logic clock = 1'b0;
  logic reset;
  logic clear;
  logic fetch_valid0;
  logic fetch_valid1;
  logic [31:0] fetch_instr0;
  logic [31:0] fetch_instr1;
  logic [31:0] fetch_pc0;
  logic [31:0] fetch_pc1;
  logic fetch_stall;
  logic retire_valid0;
  logic retire_valid1;
  logic [31:0] retire_pc0;
  logic [31:0] retire_pc1;
  logic wb_valid0;
  logic wb_valid1;
  logic [4:0] wb_addr0;
  logic [4:0] wb_addr1;
  logic [31:0] wb_data0;
  logic [31:0] wb_data1;

  instr_info sent [$];
  logic [31:0] model_regs [32];
  logic [31:0] rng_state;
  logic [31:0] next_pc;
  logic [4:0] chain_rd;
  logic saw_stall;
  int random_steps;
  int burst_pairs;
  int cycle_limit;
  int cycles = 0;
  int retired = 0;
  int flushed;
  int steps;
  int mismatch_errors = 0;
  int assert_errors = 0;
  int other_errors = 0;

  issue_top dut (.*);

  always #20 clock = ~clock;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic is_shift(input logic [3:0] kind);
    return kind == 4'd5 || kind == 4'd6 || kind == 4'd11 || kind == 4'd12;
  endfunction

  function automatic logic [31:0] encode(input instr_info info);
    logic [2:0] f3;
    logic [6:0] f7;
    case (info.kind)
      4'd0, 4'd1, 4'd7: f3 = 3'b000;
      4'd2, 4'd8: f3 = 3'b111;
      4'd3, 4'd9: f3 = 3'b110;
      4'd4, 4'd10: f3 = 3'b100;
      4'd5, 4'd11: f3 = 3'b001;
      default: f3 = 3'b101;
    endcase
    f7 = (info.kind == 4'd1) ? 7'b0100000 : 7'b0000000;
    if (info.kind == 4'd13) begin
      return 32'h0ff0000f;
    end else if (info.kind < 4'd7) begin
      return {f7, info.rs2, info.rs1, f3, info.rd, 7'b0110011};
    end
    return {info.imm[11:0], info.rs1, f3, info.rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] expected_result(input logic [3:0] kind,
                                                  input logic [31:0] a, input logic [31:0] b);
    case (kind)
      4'd0, 4'd7: return a + b;
      4'd1: return a - b;
      4'd2, 4'd8: return a & b;
      4'd3, 4'd9: return a | b;
      4'd4, 4'd10: return a ^ b;
      4'd5, 4'd11: return a << b[4:0];
      default: return a >> b[4:0];
    endcase
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    mismatch_errors++;
    $display("[FAIL] %0t %s expected %h actual %h", $time, name, expected, actual);
  endtask

  task automatic print_counts();
    $display("retired %0d, value errors %0d, assertion errors %0d, other errors %0d",
             retired, mismatch_errors, assert_errors, other_errors);
  endtask

  task automatic new_instr(output instr_info info);
    logic [31:0] r;
    rng_state = xorshift32(rng_state);
    r = rng_state;
    info.pc = next_pc;
    next_pc = next_pc + 32'd4;
    info.kind = (r[3:0] > 4'd13) ? 4'd7 : r[3:0];
    // registers x0 to x7 only, so that pairs collide often
    info.rd = {2'b00, r[6:4]};
    info.rs1 = {2'b00, r[9:7]};
    info.rs2 = {2'b00, r[12:10]};
    if (is_shift(info.kind)) begin
      info.imm = {27'd0, r[17:13]};
    end else begin
      info.imm = {{20{r[24]}}, r[24:13]};
    end
  endtask

  task automatic present(input logic v0, input logic v1, input instr_info i0,
                         input instr_info i1);
    fetch_valid0 = v0;
    fetch_valid1 = v1;
    fetch_instr0 = encode(i0);
    fetch_instr1 = encode(i1);
    fetch_pc0 = i0.pc;
    fetch_pc1 = i1.pc;
    if (v0) begin
      sent.push_back(i0);
    end
    if (v1) begin
      sent.push_back(i1);
    end
  endtask

  task automatic drive_random();
    instr_info i0;
    instr_info i1;
    logic [31:0] r;
    rng_state = xorshift32(rng_state);
    r = rng_state;
    if (r[1:0] == 2'd0) begin
      present(1'b0, 1'b0, '0, '0);
    end else if (r[1:0] == 2'd1) begin
      new_instr(i0);
      present(1'b1, 1'b0, i0, '0);
    end else begin
      new_instr(i0);
      new_instr(i1);
      present(1'b1, 1'b1, i0, i1);
    end
  endtask

  // each instruction reads the result of the one before it, which forces single issue
  task automatic drive_chain();
    instr_info i0;
    instr_info i1;
    new_instr(i0);
    new_instr(i1);
    if (i0.kind == 4'd13) begin
      i0.kind = 4'd0;
    end
    if (i0.rd == 5'd0) begin
      i0.rd = 5'd1;
    end
    if (i1.kind == 4'd13) begin
      i1.kind = 4'd7;
    end
    if (i1.rd == 5'd0) begin
      i1.rd = 5'd2;
    end
    i0.rs1 = chain_rd;
    i1.rs1 = i0.rd;
    chain_rd = i1.rd;
    present(1'b1, 1'b1, i0, i1);
  endtask

  task automatic pop_oldest(input logic [31:0] pc, output instr_info info, output logic found);
    found = sent.size() != 0;
    info = '0;
    if (found) begin
      info = sent.pop_front();
    end else begin
      other_errors++;
      $display("%0t: pc %h retired with no instruction outstanding", $time, pc);
    end
  endtask

  task automatic check_lane(input int lane, input instr_info info, input logic [31:0] pc,
                            input logic wb_v, input logic [4:0] addr, input logic [31:0] data);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] result;
    logic writes;
    a = model_regs[info.rs1];
    b = (info.kind < 4'd7) ? model_regs[info.rs2] : info.imm;
    result = expected_result(info.kind, a, b);
    writes = info.kind != 4'd13 && info.rd != 5'd0;
    retired++;
    assert (pc === info.pc) else report_mismatch($sformatf("retire_pc%0d", lane), info.pc, pc);
    assert (wb_v === writes) else report_mismatch($sformatf("wb_valid%0d", lane), writes, wb_v);
    if (writes) begin
      assert (addr === info.rd) else report_mismatch($sformatf("wb_addr%0d", lane), info.rd, addr);
      assert (data === result) else report_mismatch($sformatf("wb_data%0d", lane), result, data);
      model_regs[info.rd] = result;
    end
  endtask

  task automatic check_pair(input instr_info i0, input instr_info i1);
    logic raw;
    raw = i0.kind != 4'd13 && i0.rd != 5'd0 &&
          ((i1.kind != 4'd13 && i1.rs1 == i0.rd) || (i1.kind < 4'd7 && i1.rs2 == i0.rd));
    assert (i1.kind != 4'd13) else begin
      other_errors++;
      $display("%0t: fence at pc %h retired as the younger of a pair", $time, i1.pc);
    end
    assert (!(is_shift(i0.kind) && is_shift(i1.kind))) else begin
      other_errors++;
      $display("%0t: two shifts at pc %h and %h retired together", $time, i0.pc, i1.pc);
    end
    assert (!raw) else begin
      other_errors++;
      $display("%0t: pc %h paired with pc %h that reads its result", $time, i1.pc, i0.pc);
    end
  endtask

  task automatic check_retirements();
    instr_info i0;
    instr_info i1;
    logic found0;
    logic found1;
    found0 = 1'b0;
    found1 = 1'b0;
    if (retire_valid0) begin
      pop_oldest(retire_pc0, i0, found0);
    end
    if (retire_valid1) begin
      pop_oldest(retire_pc1, i1, found1);
    end
    if (found0 && found1) begin
      check_pair(i0, i1);
    end
    if (found0) begin
      check_lane(0, i0, retire_pc0, wb_valid0, wb_addr0, wb_data0);
    end
    if (found1) begin
      check_lane(1, i1, retire_pc1, wb_valid1, wb_addr1, wb_data1);
    end
  endtask

  task automatic advance_cycle();
    @(negedge clock);
    check_retirements();
    if (fetch_stall) begin
      saw_stall = 1'b1;
    end
  endtask

  retire_lane_order: assert property (@(posedge clock) disable iff (!reset)
    retire_valid1 |-> retire_valid0)
    else begin
      assert_errors++;
      $display("%0t: retire_valid1 high without retire_valid0", $time);
    end

  quiet_after_reset: assert property (@(posedge clock)
    !reset |=> !fetch_stall && !retire_valid0 && !retire_valid1 && !wb_valid0 && !wb_valid1)
    else begin
      assert_errors++;
      $display("%0t: stall, retire or writeback active during reset", $time);
    end

  always @(posedge clock) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("timeout after %0d cycles with %0d instructions outstanding", cycles, sent.size());
      print_counts();
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  initial begin
    random_steps = 50;
    burst_pairs = 20;
    cycle_limit = 4 * 2 * (2 * random_steps + burst_pairs) + 100;
    reset = 1'b0;
    clear = 1'b0;
    fetch_valid0 = 1'b0;
    fetch_valid1 = 1'b0;
    fetch_instr0 = '0;
    fetch_instr1 = '0;
    fetch_pc0 = '0;
    fetch_pc1 = '0;
    rng_state = 32'd9793;
    next_pc = 32'h0000_1000;
    saw_stall = 1'b0;
    model_regs = '{default: '0};
    repeat (8) @(negedge clock);
    reset = 1'b1;

    for (steps = 0; steps < random_steps; ) begin
      advance_cycle();
      if (!fetch_stall) begin
        drive_random();
        steps++;
      end
    end

    saw_stall = 1'b0;
    chain_rd = 5'd1;
    for (steps = 0; steps < burst_pairs; ) begin
      advance_cycle();
      if (!fetch_stall) begin
        drive_chain();
        steps++;
      end
    end
    assert (saw_stall) else begin
      other_errors++;
      $display("%0t: fetch_stall never rose during the dependent burst", $time);
    end

    // everything still in flight is dropped by the clear pulse
    advance_cycle();
    flushed = sent.size();
    sent.delete();
    clear = 1'b1;
    fetch_valid0 = 1'b0;
    fetch_valid1 = 1'b0;
    advance_cycle();
    clear = 1'b0;
    assert (flushed > 0) else begin
      other_errors++;
      $display("%0t: the clear pulse found no instruction in flight", $time);
    end

    for (steps = 0; steps < random_steps; ) begin
      advance_cycle();
      if (!fetch_stall) begin
        drive_random();
        steps++;
      end
    end

    while (sent.size() != 0) begin
      advance_cycle();
      if (!fetch_stall) begin
        present(1'b0, 1'b0, '0, '0);
      end
    end
    repeat (4) advance_cycle();

    print_counts();
    if (mismatch_errors + assert_errors + other_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
common/issue_pkg.sv
source/instr_decode.sv
hazard/issue_queue.sv
source/exec_unit.sv
source/issue_top.sv
tests/issue_tb.sv
